// ==== verilog/fxp_pkg.sv ====
package fxp_pkg;

	// sign-magnitude Q16.16 format
	// bit 31 is the sign, bits 30..16 integer, bits 15..0 fraction
	localparam int FXP_WIDTH = 32;
	localparam int FXP_FRAC = 16;
	localparam int FXP_MAG = FXP_WIDTH - 1;

	// pipeline shape
	localparam int NEWTON_STAGES = 5;
	// seed stage, the refinement chain and the quotient stage
	localparam int DIV_LATENCY = NEWTON_STAGES + 2;

	// width of a bit position inside the magnitude
	localparam int LEAD_W = $clog2(FXP_MAG);
	// largest seed shift that still fits the magnitude field
	localparam int SEED_MAX_SHIFT = FXP_MAG - 1;

	typedef struct packed {
		logic sign;
		logic [FXP_MAG-1:0] mag;
	} fxp_t;

	localparam fxp_t FXP_ZERO = '{sign: 1'b0, mag: '0};
	localparam fxp_t FXP_ONE = '{sign: 1'b0, mag: FXP_MAG'(1) << FXP_FRAC};
	localparam fxp_t FXP_TWO = '{sign: 1'b0, mag: FXP_MAG'(2) << FXP_FRAC};

	// one operation as it moves down the pipeline
	typedef struct packed {
		logic valid;
		logic div_zero;
		fxp_t dividend;
		// divisor with the sign flipped, the magnitude is kept as is
		fxp_t neg_divisor;
		// reciprocal estimate, always in the positive domain
		fxp_t estimate;
	} div_stage_t;

	// sign-magnitude add
	// equal signs add magnitudes and drop the carry out of bit 30,
	// unequal signs subtract the smaller magnitude from the larger
	function automatic fxp_t fxp_add(input fxp_t a, input fxp_t b);
		fxp_t res;
		if (a.sign == b.sign) begin
			res.mag = a.mag + b.mag;
			res.sign = a.sign;
		end else if (a.mag >= b.mag) begin
			res.mag = a.mag - b.mag;
			res.sign = a.sign;
		end else begin
			res.mag = b.mag - a.mag;
			res.sign = b.sign;
		end
		// no negative zero out of the adder
		if (res.mag == '0) begin
			res.sign = 1'b0;
		end
		return res;
	endfunction

	// truncating multiply
	// full 62-bit product of the magnitudes, fraction realigned by FXP_FRAC
	function automatic fxp_t fxp_mul(input fxp_t a, input fxp_t b);
		logic [2*FXP_MAG-1:0] prod;
		fxp_t res;
		prod = a.mag * b.mag;
		res.sign = a.sign ^ b.sign;
		// upper integer bits beyond bit 30 are lost
		res.mag = prod[FXP_FRAC +: FXP_MAG];
		return res;
	endfunction

endpackage

// ==== verilog/recip_seed.sv ====
module recip_seed (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fxp_pkg::fxp_t dividend,
	input fxp_pkg::fxp_t divisor,
	output fxp_pkg::div_stage_t seed_out
);

	logic [fxp_pkg::LEAD_W-1:0] lead_pos;
	logic mag_zero;
	logic [fxp_pkg::FXP_MAG-1:0] seed_mag;
	fxp_pkg::div_stage_t seed_next;

	// priority search, the highest set bit wins
	always_comb begin
		lead_pos = '0;
		for (int i = 0; i < fxp_pkg::FXP_MAG; i++) begin
			if (divisor.mag[i]) begin
				lead_pos = fxp_pkg::LEAD_W'(i);
			end
		end
	end

	assign mag_zero = (divisor.mag == '0);

	// power-of-two estimate of 1/divisor
	// lands between half and all of the true reciprocal
	always_comb begin
		if (mag_zero) begin
			seed_mag = '0;
		end else if (lead_pos == '0) begin
			// 1 << 31 does not fit, clamp to bit 30
			seed_mag = fxp_pkg::FXP_MAG'(1) << fxp_pkg::SEED_MAX_SHIFT;
		end else begin
			seed_mag = fxp_pkg::FXP_MAG'(1) << (fxp_pkg::FXP_MAG - lead_pos);
		end
	end

	always_comb begin
		seed_next.valid = in_valid;
		seed_next.div_zero = mag_zero;
		seed_next.dividend = dividend;
		seed_next.neg_divisor.sign = ~divisor.sign;
		seed_next.neg_divisor.mag = divisor.mag;
		seed_next.estimate.sign = 1'b0;
		seed_next.estimate.mag = seed_mag;
	end

	// payload only moves on a strobe, the valid bit on every edge
	always_ff @(posedge clk) begin
		if (in_valid) begin
			seed_out <= seed_next;
		end
		seed_out.valid <= in_valid;
		if (rst) begin
			seed_out.valid <= 1'b0;
		end
	end

	// a seed is a single positive power of two, or zero only for a zero divisor
	property p_seed_shape;
		@(posedge clk) disable iff (rst)
		seed_out.valid |->
			!seed_out.estimate.sign &&
			(seed_out.div_zero ? (seed_out.estimate.mag == '0)
			                   : $onehot(seed_out.estimate.mag));
	endproperty

	a_seed_shape: assert property (p_seed_shape)
		else $error("recip_seed: seed is not a power of two or zero flag disagrees");

endmodule

// ==== verilog/newton_stage.sv ====
module newton_stage (
	input logic clk,
	input logic rst,
	input fxp_pkg::div_stage_t stage_in,
	output fxp_pkg::div_stage_t stage_out
);

	// -|a|, the divisor sign itself is only applied in the quotient stage
	fxp_pkg::fxp_t neg_mag;
	// -a * x
	fxp_pkg::fxp_t ax;
	// 2 - a * x
	fxp_pkg::fxp_t corr;
	// x * (2 - a * x)
	fxp_pkg::fxp_t est_next;
	fxp_pkg::div_stage_t stage_next;

	assign neg_mag.sign = 1'b1;
	assign neg_mag.mag = stage_in.neg_divisor.mag;

	always_comb begin
		ax = fxp_pkg::fxp_mul(neg_mag, stage_in.estimate);
		corr = fxp_pkg::fxp_add(fxp_pkg::FXP_TWO, ax);
		est_next = fxp_pkg::fxp_mul(stage_in.estimate, corr);
	end

	// other fields ride along unchanged
	always_comb begin
		stage_next = stage_in;
		stage_next.estimate = est_next;
	end

	always_ff @(posedge clk) begin
		stage_out <= stage_next;
		if (rst) begin
			stage_out.valid <= 1'b0;
		end
	end

	// the seed starts below 1/a, so a*x stays under 2 and the estimate
	// stays positive through every stage of the chain
	property p_estimate_positive;
		@(posedge clk) disable iff (rst)
		stage_out.valid |-> !stage_out.estimate.sign;
	endproperty

	a_estimate_positive: assert property (p_estimate_positive)
		else $error("newton_stage: negative reciprocal estimate");

endmodule

// ==== verilog/quotient_stage.sv ====
module quotient_stage (
	input logic clk,
	input logic rst,
	input fxp_pkg::div_stage_t stage_in,
	output logic out_valid,
	output fxp_pkg::fxp_t quotient,
	output logic div_zero
);

	fxp_pkg::fxp_t prod;
	fxp_pkg::fxp_t quot_next;
	logic divisor_sign;

	// neg_divisor carries the divisor sign inverted
	assign divisor_sign = ~stage_in.neg_divisor.sign;

	// dividend * (1 / |divisor|)
	assign prod = fxp_pkg::fxp_mul(stage_in.dividend, stage_in.estimate);

	always_comb begin
		quot_next.mag = prod.mag;
		quot_next.sign = prod.sign ^ divisor_sign;
		// zero is always reported positive
		if (prod.mag == '0) begin
			quot_next.sign = 1'b0;
		end
		if (stage_in.div_zero) begin
			quot_next = fxp_pkg::FXP_ZERO;
		end
	end

	always_ff @(posedge clk) begin
		quotient <= quot_next;
		div_zero <= stage_in.div_zero;
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= stage_in.valid;
		end
	end

	// a flagged division never leaks a value out of the pipe
	property p_zero_on_flag;
		@(posedge clk) disable iff (rst)
		(out_valid && div_zero) |-> (quotient == fxp_pkg::FXP_ZERO);
	endproperty

	a_zero_on_flag: assert property (p_zero_on_flag)
		else $error("quotient_stage: nonzero quotient on a zero divisor");

endmodule

// ==== verilog/fxp_divider.sv ====
module fxp_divider (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fxp_pkg::fxp_t dividend,
	input fxp_pkg::fxp_t divisor,
	output logic out_valid,
	output fxp_pkg::fxp_t quotient,
	output logic div_zero
);

	// stage 0 from the seed, stage k+1 from newton stage k
	fxp_pkg::div_stage_t stage [fxp_pkg::NEWTON_STAGES+1];

	// leading-one seed, 1 cycle
	recip_seed recip_seed_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.dividend(dividend),
		.divisor(divisor),
		.seed_out(stage[0])
	);

	// one reciprocal refinement per stage, 1 cycle each
	// each iteration roughly doubles the number of correct bits
	for (genvar k = 0; k < fxp_pkg::NEWTON_STAGES; k++) begin : g_newton
		newton_stage newton_stage_i (
			.clk(clk),
			.rst(rst),
			.stage_in(stage[k]),
			.stage_out(stage[k+1])
		);
	end

	// dividend times the refined reciprocal, 1 cycle
	quotient_stage quotient_stage_i (
		.clk(clk),
		.rst(rst),
		.stage_in(stage[fxp_pkg::NEWTON_STAGES]),
		.out_valid(out_valid),
		.quotient(quotient),
		.div_zero(div_zero)
	);

endmodule

// ==== tests/divider_checker.sv ====
module divider_checker (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fxp_pkg::fxp_t dividend,
	input fxp_pkg::fxp_t divisor,
	input logic exact_valid,
	input fxp_pkg::fxp_t exact_quot,
	input logic exact_zero,
	input logic out_valid,
	input fxp_pkg::fxp_t quotient,
	input logic div_zero,
	input logic end_of_test,
	output int pending,
	output int error_count,
	output bit reported
);

	// one operation waiting for its result
	typedef struct packed {
		fxp_pkg::fxp_t quot;
		logic zero;
		logic op_sign;
		int issue_cycle;
	} expect_t;

	expect_t exp_q[$];
	int cycle = 0;
	int checked = 0;
	int mismatches = 0;
	int other_errors = 0;

	// sign-magnitude add, a carry out of the magnitude is lost
	function automatic logic [31:0] sm_add(input logic [31:0] a, input logic [31:0] b);
		logic [30:0] rm;
		logic rs;
		if (a[31] == b[31]) begin
			rm = a[30:0] + b[30:0];
			rs = a[31];
		end else if (a[30:0] > b[30:0]) begin
			rm = a[30:0] - b[30:0];
			rs = a[31];
		end else begin
			rm = b[30:0] - a[30:0];
			rs = b[31];
		end
		if (rm == 31'd0) begin
			rs = 1'b0;
		end
		return {rs, rm};
	endfunction

	// truncating Q16.16 multiply
	function automatic logic [31:0] sm_mul(input logic [31:0] a, input logic [31:0] b);
		logic [61:0] full;
		full = {31'd0, a[30:0]} * {31'd0, b[30:0]};
		return {a[31] ^ b[31], full[46:16]};
	endfunction

	// seed, newton chain and final multiply for one operand pair
	function automatic expect_t model_divide(input logic [31:0] num, input logic [31:0] den);
		expect_t e;
		logic [31:0] x;
		logic [31:0] neg_den;
		logic [31:0] q;
		int top;
		top = -1;
		for (int i = 0; i < 31; i++) begin
			if (den[i]) begin
				top = i;
			end
		end
		if (top < 0) begin
			x = 32'd0;
		end else if (top == 0) begin
			x = 32'h4000_0000;
		end else begin
			x = 32'd1 << (31 - top);
		end
		// -|den|, the divisor sign is applied to the quotient
		neg_den = {1'b1, den[30:0]};
		for (int k = 0; k < fxp_pkg::NEWTON_STAGES; k++) begin
			x = sm_mul(x, sm_add(fxp_pkg::FXP_TWO, sm_mul(neg_den, x)));
		end
		q = sm_mul(num, x);
		q[31] = q[31] ^ den[31];
		if (q[30:0] == 31'd0 || top < 0) begin
			q = 32'd0;
		end
		e.quot = q;
		e.zero = (top < 0);
		e.op_sign = num[31] ^ den[31];
		e.issue_cycle = 0;
		return e;
	endfunction

	// operands are stable at the rising edge
	// a strobe belongs to the cycle that this edge closes
	always @(posedge clk) begin
		expect_t e;
		if (!rst && in_valid) begin
			e = model_divide(dividend, divisor);
			if (exact_valid) begin
				e.quot = exact_quot;
				e.zero = exact_zero;
			end
			e.issue_cycle = cycle;
			exp_q.push_back(e);
		end
		cycle = cycle + 1;
	end

	// results are read mid-cycle, after the registers have settled
	always @(negedge clk) begin
		expect_t e;
		if (!rst && $isunknown(out_valid)) begin
			other_errors++;
			$display("Error at %0t: out_valid is unknown after reset", $time);
		end else if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("Error at %0t: out_valid pulse with no operation in flight", $time);
			end else begin
				e = exp_q.pop_front();
				checked++;
				if (cycle - e.issue_cycle != fxp_pkg::DIV_LATENCY) begin
					other_errors++;
					$display("Error at %0t: result came %0d cycles after its strobe, not %0d",
						$time, cycle - e.issue_cycle, fxp_pkg::DIV_LATENCY);
				end
				if (div_zero !== e.zero) begin
					mismatches++;
					$display("Mismatch at %0t: div_zero expected %b got %b",
						$time, e.zero, div_zero);
				end
				if (quotient !== e.quot) begin
					mismatches++;
					$display("Mismatch at %0t: quotient expected %h got %h",
						$time, e.quot, quotient);
				end
				// the sign rule on its own, independent of the magnitude
				if (!div_zero && quotient.mag != '0 && quotient.sign !== e.op_sign) begin
					mismatches++;
					$display("Mismatch at %0t: quotient.sign expected %b got %b",
						$time, e.op_sign, quotient.sign);
				end
			end
		end
		pending = exp_q.size();
		if (end_of_test && !reported) begin
			if (exp_q.size() != 0) begin
				other_errors++;
				$display("Error: %0d operations never produced a result", exp_q.size());
			end
			$display("checker: %0d results checked, %0d mismatches, %0d other errors",
				checked, mismatches, other_errors);
			reported = 1'b1;
		end
		error_count = mismatches + other_errors;
	end

endmodule

// ==== tests/tb_fxp_divider.sv ====
module tb_fxp_divider;

	localparam int RESET_CYCLES = 10;
	localparam int TABLE_LEN = 16;
	localparam int RANDOM_PAIRS = 200;

	// gap is the number of idle cycles before the strobe
	// exact rows carry their quotient, the others use the checker model
	typedef struct packed {
		logic [7:0] gap;
		logic exact;
		logic zero;
		fxp_pkg::fxp_t num;
		fxp_pkg::fxp_t den;
		fxp_pkg::fxp_t quot;
	} stim_t;

	logic clk;
	logic rst;
	logic in_valid;
	fxp_pkg::fxp_t dividend;
	fxp_pkg::fxp_t divisor;
	logic out_valid;
	fxp_pkg::fxp_t quotient;
	logic div_zero;

	logic exact_valid;
	fxp_pkg::fxp_t exact_quot;
	logic exact_zero;
	logic end_of_test;
	int pending;
	int error_count;
	bit reported;

	stim_t stim_table [TABLE_LEN];
	int cycle_count;
	int cycle_limit;
	logic [31:0] rnd;

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	fxp_divider fxp_divider_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.dividend(dividend),
		.divisor(divisor),
		.out_valid(out_valid),
		.quotient(quotient),
		.div_zero(div_zero)
	);

	divider_checker divider_checker_i (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.dividend(dividend),
		.divisor(divisor),
		.exact_valid(exact_valid),
		.exact_quot(exact_quot),
		.exact_zero(exact_zero),
		.out_valid(out_valid),
		.quotient(quotient),
		.div_zero(div_zero),
		.end_of_test(end_of_test),
		.pending(pending),
		.error_count(error_count),
		.reported(reported)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic stim_t stim_entry(input int gap, input logic exact, input logic zero,
		input logic [31:0] num, input logic [31:0] den, input logic [31:0] quot);
		stim_t e;
		e.gap = 8'(gap);
		e.exact = exact;
		e.zero = zero;
		e.num = num;
		e.den = den;
		e.quot = quot;
		return e;
	endfunction

	task automatic load_table();
		// zero dividends give a positive zero, negative zero included
		stim_table[0] = stim_entry(3, 1'b1, 1'b0, 32'h0000_0000, 32'h0003_0000, 32'h0);
		stim_table[1] = stim_entry(0, 1'b1, 1'b0, 32'h8000_0000, 32'h8005_0000, 32'h0);
		// zero divisors raise the flag whatever the dividend
		stim_table[2] = stim_entry(0, 1'b1, 1'b1, 32'h0000_0000, 32'h0000_0000, 32'h0);
		stim_table[3] = stim_entry(1, 1'b1, 1'b1, 32'h0007_8000, 32'h0000_0000, 32'h0);
		stim_table[4] = stim_entry(0, 1'b1, 1'b1, 32'h8003_4000, 32'h8000_0000, 32'h0);
		// 10 / 4 on all four sign combinations
		stim_table[5] = stim_entry(0, 1'b0, 1'b0, 32'h000A_0000, 32'h0004_0000, 32'h0);
		stim_table[6] = stim_entry(0, 1'b0, 1'b0, 32'h800A_0000, 32'h0004_0000, 32'h0);
		stim_table[7] = stim_entry(0, 1'b0, 1'b0, 32'h000A_0000, 32'h8004_0000, 32'h0);
		stim_table[8] = stim_entry(0, 1'b0, 1'b0, 32'h800A_0000, 32'h8004_0000, 32'h0);
		// uneven gaps between strobes
		stim_table[9] = stim_entry(3, 1'b0, 1'b0, 32'h0001_8000, 32'h0000_C000, 32'h0);
		stim_table[10] = stim_entry(1, 1'b0, 1'b0, 32'h0064_0000, 32'h0007_0000, 32'h0);
		stim_table[11] = stim_entry(5, 1'b0, 1'b0, 32'h0001_0000, 32'h0003_0000, 32'h0);
		stim_table[12] = stim_entry(2, 1'b0, 1'b0, 32'h0000_8000, 32'h03E8_0000, 32'h0);
		stim_table[13] = stim_entry(7, 1'b0, 1'b0, 32'h3039_AD91, 32'h8000_0042, 32'h0);
		stim_table[14] = stim_entry(4, 1'b0, 1'b0, 32'hFFFF_8000, 32'h0002_8000, 32'h0);
		stim_table[15] = stim_entry(10, 1'b1, 1'b0, 32'h0000_0000, 32'h8000_0042, 32'h0);
	endtask

	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		exact_valid = 1'b0;
	endtask

	task automatic drive_pair(input logic [31:0] num, input logic [31:0] den,
		input logic exact, input logic [31:0] quot, input logic zero);
		@(negedge clk);
		in_valid = 1'b1;
		dividend = num;
		divisor = den;
		exact_valid = exact;
		exact_quot = quot;
		exact_zero = zero;
	endtask

	initial begin
		int table_cycles;
		logic [31:0] num;
		logic [31:0] den;
		rst = 1'b1;
		in_valid = 1'b0;
		dividend = '0;
		divisor = '0;
		exact_valid = 1'b0;
		exact_quot = '0;
		exact_zero = 1'b0;
		end_of_test = 1'b0;
		rnd = 32'h6310;
		load_table();
		table_cycles = 0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			table_cycles = table_cycles + int'(stim_table[i].gap) + 1;
		end
		cycle_limit = RESET_CYCLES + table_cycles + RANDOM_PAIRS + 2 * fxp_pkg::DIV_LATENCY + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			repeat (int'(stim_table[i].gap)) drive_idle();
			drive_pair(stim_table[i].num, stim_table[i].den, stim_table[i].exact,
				stim_table[i].quot, stim_table[i].zero);
		end
		// back to back random pairs
		for (int n = 0; n < RANDOM_PAIRS; n++) begin
			rnd = next_random(rnd);
			num = rnd;
			rnd = next_random(rnd);
			den = rnd;
			rnd = next_random(rnd);
			// spread divisors over many magnitudes but keep 1/den inside the format
			den[30:0] = den[30:0] >> (rnd % 32'd24);
			if (den[30:0] < 31'd4) begin
				den[30:0] = den[30:0] | 31'd4;
			end
			drive_pair(num, den, 1'b0, 32'h0, 1'b0);
		end
		drive_idle();
		while (pending != 0) begin
			@(posedge clk);
		end
		// any pulse after the last result is an extra one
		repeat (fxp_pkg::DIV_LATENCY + 2) @(posedge clk);
		end_of_test = 1'b1;
		wait (reported);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		@(posedge clk);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/fxp_pkg.sv
verilog/recip_seed.sv
verilog/newton_stage.sv
verilog/quotient_stage.sv
verilog/fxp_divider.sv
tests/divider_checker.sv
tests/tb_fxp_divider.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the divider testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_fxp_divider -f flist.f || exit 1
sim_out=$(./obj_dir/Vtb_fxp_divider)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
